// ==== compile.f ====
+incdir+rtl
rtl/cpu_pkg.sv
rtl/issue_if.sv
rtl/fetch_queue.sv
rtl/instr_decode.sv
rtl/instr_issue.sv
rtl/issue_pipe.sv
rtl/dual_issue_front.sv
sim/tb_dual_issue_front.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the testbench, exit status follows the result.
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f compile.f --top-module tb_dual_issue_front -o tb_sim
./obj_dir/tb_sim

// ==== sim/tb_dual_issue_front.sv ====
`timescale 1ns/100ps
`include "cpu_defs.svh"

module tb_dual_issue_front;

	localparam int P1_PAIRS = 16;
	localparam int P2_PAIRS = 6;
	localparam int P3_PAIRS = 300;
	localparam int TOTAL_PAIRS = P1_PAIRS + P2_PAIRS + P3_PAIRS;
	localparam int TOTAL_WORDS = TOTAL_PAIRS * `ISSUE_NUM;
	localparam int P1_WORDS = P1_PAIRS * `ISSUE_NUM;
	localparam int TIMEOUT_CYCLES = 4 * TOTAL_PAIRS + 200;

	logic clk;
	logic rst_n;
	logic in_valid;
	cpu_pkg::uint32_t in_instr0;
	cpu_pkg::uint32_t in_instr1;
	logic in_ready;
	logic out_valid0;
	logic out_valid1;
	cpu_pkg::uint32_t out_instr0;
	cpu_pkg::uint32_t out_instr1;

	integer seed = 32'hd2f6_4e39;
	cpu_pkg::uint32_t exp_q[$]; // Accepted words, oldest first.
	int rx_count = 0;
	int pushed_pairs = 0;
	int cycle_count = 0;
	cpu_pkg::reg_addr_t prev_load_rd = '0;
	cpu_pkg::reg_addr_t cur_load_rd;

	dual_issue_front i_dual_issue_front (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_instr0  (in_instr0),
		.in_instr1  (in_instr1),
		.in_ready   (in_ready),
		.out_valid0 (out_valid0),
		.out_valid1 (out_valid1),
		.out_instr0 (out_instr0),
		.out_instr1 (out_instr1)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic cpu_pkg::uint32_t r_type(input logic [5:0] funct,
		input cpu_pkg::reg_addr_t rs, input cpu_pkg::reg_addr_t rt,
		input cpu_pkg::reg_addr_t rd);
		return {6'b000000, rs, rt, rd, 5'b00000, funct};
	endfunction

	function automatic cpu_pkg::uint32_t i_type(input logic [5:0] op,
		input cpu_pkg::reg_addr_t rs, input cpu_pkg::reg_addr_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Field extraction by opcode class.
	function automatic cpu_pkg::decoded_instr_t decode_ref(input cpu_pkg::uint32_t w);
		cpu_pkg::decoded_instr_t d;
		d = '0;
		d.instr = w;
		d.rs1 = w[25:21];
		d.rs2 = w[20:16];
		if (w[31:26] == 6'b000000 || w[31:26] == 6'b011100) begin
			d.rd = w[15:11];
		end else if (w[31:29] == 3'b001) begin
			d.rs2 = '0;
			d.rd = w[20:16];
		end else if (w[31:29] == 3'b100) begin
			d.rs2 = '0;
			d.rd = w[20:16];
			d.is_load = 1'b1;
		end else if (w[31:29] == 3'b101) begin
			d.is_store = 1'b1;
		end
		return d;
	endfunction

	function automatic logic hilo_ref(input cpu_pkg::uint32_t w);
		logic hit;
		hit = 1'b0;
		if (w[31:26] == 6'b000000) begin
			case (w[5:0])
				6'h10, 6'h11, 6'h12, 6'h13, 6'h18, 6'h19, 6'h1a, 6'h1b: hit = 1'b1;
				default: hit = 1'b0;
			endcase
		end else if (w[31:26] == 6'b011100) begin
			case (w[5:0])
				6'h00, 6'h01, 6'h04, 6'h05: hit = 1'b1; // MADD(U), MSUB(U).
				default: hit = 1'b0;
			endcase
		end
		return hit;
	endfunction

	function automatic logic pair_ok(input cpu_pkg::uint32_t w0, input cpu_pkg::uint32_t w1);
		cpu_pkg::decoded_instr_t d0;
		cpu_pkg::decoded_instr_t d1;
		logic raw;
		logic both_mem;
		d0 = decode_ref(w0);
		d1 = decode_ref(w1);
		raw = d0.rd != '0 && (d1.rs1 == d0.rd || d1.rs2 == d0.rd);
		both_mem = (d0.is_load | d0.is_store) & (d1.is_load | d1.is_store);
		return !raw && !both_mem && !(hilo_ref(w0) && hilo_ref(w1));
	endfunction

	task automatic abort_run(input string msg);
		$display("STATUS: FAIL");
		$fatal(1, "%s", msg);
	endtask

	task automatic report_mismatch(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		abort_run("Output check failed, run stopped.");
	endtask

	task automatic check_word(input cpu_pkg::uint32_t w);
		cpu_pkg::decoded_instr_t d;
		assert (exp_q.size() > 0)
			else abort_run("The DUT issued a word that was never pushed.");
		assert (w == exp_q[0])
			else report_mismatch($sformatf("got %08h, expected %08h", w, exp_q[0]));
		void'(exp_q.pop_front());
		rx_count++;
		d = decode_ref(w);
		assert (prev_load_rd == '0 || (d.rs1 != prev_load_rd && d.rs2 != prev_load_rd))
			else report_mismatch($sformatf("%08h uses r%0d right after its load",
				w, prev_load_rd));
		if (d.is_load)
			cur_load_rd = d.rd;
	endtask

	// Scoreboard, checks and timeout.
	always @(posedge clk) begin
		if (rst_n) begin
			cycle_count++;
			if (cycle_count > TIMEOUT_CYCLES)
				abort_run("Timeout, the accepted instructions did not all come out.");
			cur_load_rd = '0;
			assert (out_valid0 || !out_valid1)
				else report_mismatch("out_valid1 high while out_valid0 is low");
			if (out_valid0 && rx_count < P1_WORDS)
				assert (out_valid1) else report_mismatch("single issue in the ALU pair phase");
			if (out_valid0 && out_valid1)
				assert (pair_ok(out_instr0, out_instr1))
					else report_mismatch($sformatf("illegal pair %08h %08h", out_instr0, out_instr1));
			if (out_valid0)
				check_word(out_instr0);
			if (out_valid1)
				check_word(out_instr1);
			prev_load_rd = cur_load_rd;
			if (in_valid && in_ready) begin // Pair accepted at this edge.
				exp_q.push_back(in_instr0);
				exp_q.push_back(in_instr1);
				pushed_pairs++;
			end
		end
	end

	task automatic push_pair(input cpu_pkg::uint32_t w0, input cpu_pkg::uint32_t w1);
		in_valid <= 1'b1;
		in_instr0 <= w0;
		in_instr1 <= w1;
		do
			@(posedge clk);
		while (!in_ready); // Held until taken.
	endtask

	task automatic idle_cycles(input int n);
		in_valid <= 1'b0;
		repeat (n) @(posedge clk);
	endtask

	// Register pool r0..r7 to provoke hazards.
	task automatic rand_word(output cpu_pkg::uint32_t w);
		logic [31:0] r;
		cpu_pkg::reg_addr_t a;
		cpu_pkg::reg_addr_t b;
		cpu_pkg::reg_addr_t c;
		r = $random(seed);
		a = {2'b00, r[5:3]};
		b = {2'b00, r[8:6]};
		c = {2'b00, r[11:9]};
		case (r[2:0])
			3'd0: w = r_type(6'h21, a, b, c);
			3'd1: w = i_type(6'h09, a, b, r[31:16]);
			3'd2: w = i_type(6'h23, a, b, r[31:16]); // LW.
			3'd3: w = i_type(6'h2b, a, b, r[31:16]); // SW.
			3'd4: w = r_type(6'h18, a, b, 5'd0);
			3'd5: w = r_type(6'h12, 5'd0, 5'd0, c);
			3'd6: w = {6'b011100, a, b, 10'd0, 6'h00};
			default: w = 32'h0000_0000; // NOP.
		endcase
	endtask

	initial begin : stimulus
		cpu_pkg::uint32_t w0;
		cpu_pkg::uint32_t w1;
		logic [31:0] gap;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_instr0 = '0;
		in_instr1 = '0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		repeat (3) begin
			@(posedge clk);
			assert (in_ready && !out_valid0 && !out_valid1)
				else report_mismatch("wrong in_ready or out_valid after reset");
		end
		for (int i = 0; i < P1_PAIRS; i++)
			push_pair(r_type(6'h21, 5'd1, 5'd2, 5'(8 + i % 8)),
				i_type(6'h09, 5'd3, 5'(16 + i % 8), 16'(i)));
		push_pair(r_type(6'h21, 5'd1, 5'd2, 5'd5), r_type(6'h21, 5'd5, 5'd2, 5'd6));
		push_pair(i_type(6'h23, 5'd1, 5'd7, 16'h0010), i_type(6'h2b, 5'd1, 5'd2, 16'h0014));
		push_pair(r_type(6'h18, 5'd1, 5'd2, 5'd0), r_type(6'h12, 5'd0, 5'd0, 5'd9));
		push_pair(i_type(6'h23, 5'd1, 5'd10, 16'h0020), r_type(6'h21, 5'd10, 5'd2, 5'd11));
		push_pair(i_type(6'h23, 5'd3, 5'd12, 16'h0024), i_type(6'h09, 5'd4, 5'd13, 16'h0001));
		push_pair(r_type(6'h21, 5'd12, 5'd4, 5'd14), r_type(6'h21, 5'd1, 5'd2, 5'd15));
		for (int i = 0; i < P3_PAIRS; i++) begin
			rand_word(w0);
			rand_word(w1);
			gap = $random(seed);
			if (gap[1:0] == 2'b00)
				idle_cycles(gap[2] ? 2 : 1);
			push_pair(w0, w1);
		end
		in_valid <= 1'b0;
		while (rx_count < TOTAL_WORDS)
			@(negedge clk);
		repeat (5) @(negedge clk); // Catch duplicates.
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== rtl/dual_issue_front.sv ====
`timescale 1ns/100ps
`include "cpu_defs.svh"

module dual_issue_front (
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid,
	input  cpu_pkg::uint32_t in_instr0,
	input  cpu_pkg::uint32_t in_instr1,
	output logic in_ready,
	output logic out_valid0,
	output logic out_valid1,
	output cpu_pkg::uint32_t out_instr0,
	output cpu_pkg::uint32_t out_instr1
);

	cpu_pkg::fetch_entry_t   [`ISSUE_NUM-1:0] fetch_entry;
	cpu_pkg::decoded_instr_t [`ISSUE_NUM-1:0] id_decoded;
	logic [1:0] pop_num;

	issue_if issue_bus ();

	// Nothing leaves the queue on a stall.
	assign pop_num = issue_bus.stall_req ? 2'd0 : issue_bus.issue_num;

	fetch_queue i_fetch_queue (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.in_instr0   (in_instr0),
		.in_instr1   (in_instr1),
		.in_ready    (in_ready),
		.pop_num     (pop_num),
		.fetch_entry (fetch_entry)
	);

	for (genvar i = 0; i < `ISSUE_NUM; i++) begin : gen_decode
		instr_decode i_instr_decode (
			.entry   (fetch_entry[i]),
			.decoded (id_decoded[i])
		);
	end

	instr_issue i_instr_issue (
		.fetch_entry (fetch_entry),
		.id_decoded  (id_decoded),
		.iss         (issue_bus.issue)
	);

	issue_pipe i_issue_pipe (
		.clk        (clk),
		.rst_n      (rst_n),
		.iss        (issue_bus.pipe),
		.out_valid0 (out_valid0),
		.out_valid1 (out_valid1),
		.out_instr0 (out_instr0),
		.out_instr1 (out_instr1)
	);

endmodule

// ==== rtl/issue_pipe.sv ====
`timescale 1ns/100ps
`include "cpu_defs.svh"

module issue_pipe (
	input  logic clk,
	input  logic rst_n,
	issue_if.pipe iss,
	output logic out_valid0,
	output logic out_valid1,
	output cpu_pkg::uint32_t out_instr0,
	output cpu_pkg::uint32_t out_instr1
);

	cpu_pkg::decoded_instr_t [`ISSUE_NUM-1:0] ex_q;
	logic [`ISSUE_NUM-1:0] ex_valid; // NOP words are legal, so valid is kept apart.

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_q     <= '0;
			ex_valid <= '0;
		end else if (iss.stall_req) begin
			ex_q     <= '0; // Bubble.
			ex_valid <= '0;
		end else begin
			ex_q        <= iss.issue_instr;
			ex_valid[0] <= (iss.issue_num >= 2'd1);
			ex_valid[1] <= (iss.issue_num >= 2'd2);
		end
	end

	assign iss.ex_decoded = ex_q;

	assign out_valid0 = ex_valid[0];
	assign out_valid1 = ex_valid[1];
	assign out_instr0 = ex_q[0].instr;
	assign out_instr1 = ex_q[1].instr;

endmodule

// ==== rtl/instr_issue.sv ====
`timescale 1ns/100ps
`include "cpu_defs.svh"

module instr_issue (
	input  cpu_pkg::fetch_entry_t   [`ISSUE_NUM-1:0] fetch_entry,
	input  cpu_pkg::decoded_instr_t [`ISSUE_NUM-1:0] id_decoded,
	issue_if.issue iss
);

	logic second_dropped;
	logic [`ISSUE_NUM-1:0] instr_valid;
	logic [`ISSUE_NUM-1:0] load_related;
	logic [`ISSUE_NUM-1:0] mem_access;
	logic [`ISSUE_NUM-1:0] hilo_access;

	function automatic logic is_hilo(input cpu_pkg::uint32_t instr);
		logic special_hilo;
		logic special2_hilo;
		// MFHI, MTHI, MFLO, MTLO, MULT, MULTU, DIV, DIVU.
		special_hilo = instr[31:26] == 6'b000000 && instr[5:4] == 2'b01 && instr[2] == 1'b0;
		// MADD, MADDU, MSUB, MSUBU.
		special2_hilo = instr[31:26] == 6'b011100 && instr[5:3] == 3'b000 && instr[1] == 1'b0;
		return special_hilo | special2_hilo;
	endfunction

	function automatic logic reads_load(
		input cpu_pkg::decoded_instr_t id,
		input cpu_pkg::decoded_instr_t ex
	);
		return ex.is_load && ex.rd != '0 && (id.rs1 == ex.rd || id.rs2 == ex.rd);
	endfunction

	function automatic logic reads_rd(
		input cpu_pkg::decoded_instr_t older,
		input cpu_pkg::decoded_instr_t younger
	);
		return older.rd != '0 && (younger.rs1 == older.rd || younger.rs2 == older.rd);
	endfunction

	for (genvar i = 0; i < `ISSUE_NUM; i++) begin : gen_class
		assign instr_valid[i] = fetch_entry[i].valid;
		assign mem_access[i]  = id_decoded[i].is_load | id_decoded[i].is_store;
		assign hilo_access[i] = is_hilo(fetch_entry[i].instr);
	end

	always_comb begin
		load_related = '0;
		for (int i = 0; i < `ISSUE_NUM; i++) begin
			for (int j = 0; j < `ISSUE_NUM; j++)
				load_related[i] |= reads_load(id_decoded[i], iss.ex_decoded[j]);
		end
		load_related &= instr_valid; // Empty slots never stall.
	end

	assign second_dropped = ~instr_valid[1]
		| reads_rd(id_decoded[0], id_decoded[1])
		| (mem_access[0] & mem_access[1])
		| (hilo_access[0] & hilo_access[1]);

	assign iss.stall_req = (|load_related) | (instr_valid == '0);

	always_comb begin
		iss.issue_instr = id_decoded;
		iss.issue_num   = 2'd2;
		if (second_dropped) begin
			iss.issue_instr[1] = '0;
			iss.issue_num      = 2'd1;
		end
	end

endmodule

// ==== rtl/instr_decode.sv ====
`timescale 1ns/100ps

module instr_decode (
	input  cpu_pkg::fetch_entry_t entry,
	output cpu_pkg::decoded_instr_t decoded
);

	logic [5:0] opcode;
	cpu_pkg::reg_addr_t rs_f;
	cpu_pkg::reg_addr_t rt_f;
	cpu_pkg::reg_addr_t rd_f;

	assign opcode = entry.instr[31:26];
	assign rs_f   = entry.instr[25:21];
	assign rt_f   = entry.instr[20:16];
	assign rd_f   = entry.instr[15:11];

	always_comb begin
		decoded = '0;
		if (entry.valid) begin
			// Word passes through for HI/LO checks.
			decoded.instr = entry.instr;
			decoded.rs1   = rs_f;
			decoded.rs2   = rt_f;
			decoded.rd    = '0;
			casez (opcode)
				6'b000000,
				6'b011100: begin // R-type and SPECIAL2.
					decoded.rd = rd_f;
				end
				6'b001???: begin // Immediate ALU ops.
					decoded.rs2 = '0;
					decoded.rd  = rt_f;
				end
				6'b100???: begin
					decoded.rs2     = '0;
					decoded.rd      = rt_f;
					decoded.is_load = 1'b1;
				end
				6'b101???: begin
					decoded.is_store = 1'b1;
				end
				default: begin
					// Branches and others write nothing.
					decoded.rd = '0;
				end
			endcase
		end
	end

endmodule

// ==== rtl/fetch_queue.sv ====
`timescale 1ns/100ps
`include "cpu_defs.svh"

module fetch_queue (
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid,
	input  cpu_pkg::uint32_t in_instr0,
	input  cpu_pkg::uint32_t in_instr1,
	output logic in_ready,
	input  logic [1:0] pop_num,
	output cpu_pkg::fetch_entry_t [`ISSUE_NUM-1:0] fetch_entry
);

	localparam int PTR_W = $clog2(`FQ_DEPTH);
	localparam int CNT_W = PTR_W + 1;

	cpu_pkg::uint32_t mem [`FQ_DEPTH];

	logic [PTR_W-1:0] rd_ptr, rd_ptr1;
	logic [PTR_W-1:0] wr_ptr, wr_ptr1;
	logic [CNT_W-1:0] count, count_next;
	logic [CNT_W-1:0] pop_cnt;
	logic push;

	assign push    = in_valid & in_ready;
	assign rd_ptr1 = rd_ptr + 1'b1;
	assign wr_ptr1 = wr_ptr + 1'b1;

	// Never pop more than is held.
	assign pop_cnt = (CNT_W'(pop_num) > count) ? count : CNT_W'(pop_num);

	assign count_next = count + (push ? CNT_W'(`ISSUE_NUM) : '0) - pop_cnt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_ptr   <= '0;
			wr_ptr   <= '0;
			count    <= '0;
			in_ready <= 1'b1;
		end else begin
			rd_ptr <= rd_ptr + pop_cnt[PTR_W-1:0];
			if (push)
				wr_ptr <= wr_ptr + PTR_W'(`ISSUE_NUM);
			count <= count_next;
			// Room for a full pair next cycle.
			in_ready <= (count_next <= CNT_W'(`FQ_DEPTH - `ISSUE_NUM));
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr]  <= in_instr0; // Older word first.
			mem[wr_ptr1] <= in_instr1;
		end
	end

	always_comb begin
		fetch_entry[0].valid = (count >= CNT_W'(1));
		fetch_entry[0].instr = mem[rd_ptr];
		fetch_entry[1].valid = (count >= CNT_W'(2));
		fetch_entry[1].instr = mem[rd_ptr1];
	end

endmodule

// ==== rtl/issue_if.sv ====
`timescale 1ns/100ps
`include "cpu_defs.svh"

interface issue_if;
	cpu_pkg::decoded_instr_t [`ISSUE_NUM-1:0] issue_instr;
	logic [1:0] issue_num;
	logic stall_req;
	cpu_pkg::decoded_instr_t [`ISSUE_NUM-1:0] ex_decoded; // Instructions now in EX.

	modport issue(output issue_instr, issue_num, stall_req, input ex_decoded);

	modport pipe(input issue_instr, issue_num, stall_req, output ex_decoded);
endinterface

// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

	// Instruction word.
	typedef logic [31:0] uint32_t;

	// Architectural register number. Zero means none.
	typedef logic [4:0] reg_addr_t;

	typedef struct packed {
		logic    valid;
		uint32_t instr;
	} fetch_entry_t;

	// All zero is a bubble.
	typedef struct packed {
		uint32_t   instr;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		logic      is_load;
		logic      is_store;
	} decoded_instr_t;

endpackage

// ==== rtl/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Instructions examined and issued per cycle.
// The pairing logic only handles two.
`define ISSUE_NUM 2

// Fetch queue entries.
// Must be a power of two and at least 4.
`define FQ_DEPTH 8

`endif
